// ==== cgra_pkg.sv ====
package cgra_pkg;

	// configuration bus words.
	typedef logic [31:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;

	// address split: tile id in the low half, block code in the high half.
	typedef logic [15:0] tile_id_t;
	typedef logic [15:0] block_id_t;

	localparam int TILE_FIELD_LSB = 0;
	localparam int BLOCK_FIELD_LSB = 16;

	// block codes.
	localparam block_id_t BLOCK_SB = 16'd7;
	localparam block_id_t BLOCK_CB0 = 16'd6;
	localparam block_id_t BLOCK_CB1 = 16'd5;
	localparam block_id_t BLOCK_CLB = 16'd4;

	// logic block operation.
	typedef logic [1:0] clb_op_t;

	localparam clb_op_t OP_AND = 2'd0;
	localparam clb_op_t OP_OR = 2'd1;
	localparam clb_op_t OP_XOR = 2'd2;
	localparam clb_op_t OP_NAND = 2'd3;

	// connect box choice, msb picks outgoing tracks.
	typedef logic [2:0] cb_sel_t;

	// switch box source per output track.
	typedef logic [1:0] sb_choice_t;

	localparam sb_choice_t SB_FROM_PE = 2'd3;

	// sides per tile, side 3 only drives in.
	localparam int NUM_IN_SIDES = 4;
	localparam int NUM_OUT_SIDES = 3;

endpackage

// ==== clb.sv ====
`timescale 1ns/1ps

module clb (
	input  logic                clk,
	input  logic                rst,
	input  logic                config_en,
	input  cgra_pkg::clb_op_t   config_data,
	input  logic                in0,
	input  logic                in1,
	output logic                out
);

	cgra_pkg::clb_op_t op_q;
	logic result;

	// operation register.
	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= cgra_pkg::OP_AND;
		end else if (config_en) begin
			op_q <= config_data;
		end
	end

	always_comb begin
		case (op_q)
			cgra_pkg::OP_AND: result = in0 & in1;
			cgra_pkg::OP_OR: result = in0 | in1;
			cgra_pkg::OP_XOR: result = in0 ^ in1;
			cgra_pkg::OP_NAND: result = ~(in0 & in1);
			default: result = 1'b0;
		endcase
	end

	// registered result, this breaks any route back through the switch box.
	always_ff @(posedge clk) begin
		if (rst) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

	// first computed value after reset must be known.
	a_out_known: assert property (
		@(posedge clk)
		$fell(rst) |=> !$isunknown(out)
	) else $error("clb: output unknown after reset release");

endmodule

// ==== connect_box.sv ====
`timescale 1ns/1ps

module connect_box #(
	parameter int NUM_TRACKS = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  config_en,
	input  cgra_pkg::cb_sel_t     config_data,
	input  logic [NUM_TRACKS-1:0] side_in,
	input  logic [NUM_TRACKS-1:0] side_out,
	output logic                  block_out
);

	cgra_pkg::cb_sel_t sel_q;
	logic [1:0] track_idx;
	logic use_out;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0; // in track 0.
		end else if (config_en) begin
			sel_q <= config_data;
		end
	end

	assign track_idx = sel_q[1:0];
	assign use_out = sel_q[2]; // upper four choices read the outgoing side.

	// pick one track of the side.
	always_comb begin
		block_out = 1'b0;
		for (int t = 0; t < NUM_TRACKS; t++) begin
			if (int'(track_idx) == t) begin
				block_out = use_out ? side_out[t] : side_in[t];
			end
		end
	end

	// a written choice must name an existing track.
	a_sel_in_range: assert property (
		@(posedge clk) disable iff (rst)
		config_en |=> (int'(track_idx) < NUM_TRACKS)
	) else $error("connect_box: track choice %0d beyond %0d tracks", track_idx, NUM_TRACKS);

endmodule

// ==== filelist.f ====
cgra_pkg.sv
connect_box.sv
switch_box.sv
clb.sv
pe_tile_top.sv
tb_pe_tile_top.sv

// ==== pe_tile_top.sv ====
`timescale 1ns/1ps

module pe_tile_top #(
	parameter int NUM_TRACKS = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  cgra_pkg::cfg_addr_t   config_addr,
	input  cgra_pkg::cfg_data_t   config_data,
	input  cgra_pkg::tile_id_t    tile_id,
	input  logic [NUM_TRACKS-1:0] in_wire_0,
	input  logic [NUM_TRACKS-1:0] in_wire_1,
	input  logic [NUM_TRACKS-1:0] in_wire_2,
	input  logic [NUM_TRACKS-1:0] in_wire_3,
	output logic [NUM_TRACKS-1:0] out_wire_0,
	output logic [NUM_TRACKS-1:0] out_wire_1,
	output logic [NUM_TRACKS-1:0] out_wire_2
);

	cgra_pkg::tile_id_t addr_tile;
	cgra_pkg::block_id_t addr_block;
	logic tile_hit;

	logic config_en_sb;
	logic config_en_cb0;
	logic config_en_cb1;
	logic config_en_clb;

	logic op_0;
	logic op_1;
	logic pe_output;

	// address fields.
	assign addr_tile = config_addr[cgra_pkg::TILE_FIELD_LSB +: $bits(cgra_pkg::tile_id_t)];
	assign addr_block = config_addr[cgra_pkg::BLOCK_FIELD_LSB +: $bits(cgra_pkg::block_id_t)];

	assign tile_hit = (addr_tile == tile_id);

	// one write strobe per block, no handshake.
	assign config_en_sb = tile_hit && (addr_block == cgra_pkg::BLOCK_SB);
	assign config_en_cb0 = tile_hit && (addr_block == cgra_pkg::BLOCK_CB0);
	assign config_en_cb1 = tile_hit && (addr_block == cgra_pkg::BLOCK_CB1);
	assign config_en_clb = tile_hit && (addr_block == cgra_pkg::BLOCK_CLB);

	// operand a from side 0.
	connect_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) cb0 (
		.clk(clk),
		.rst(rst),
		.config_en(config_en_cb0),
		.config_data(config_data[2:0]),
		.side_in(in_wire_0),
		.side_out(out_wire_0),
		.block_out(op_0)
	);

	// operand b from side 1.
	connect_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) cb1 (
		.clk(clk),
		.rst(rst),
		.config_en(config_en_cb1),
		.config_data(config_data[2:0]),
		.side_in(in_wire_1),
		.side_out(out_wire_1),
		.block_out(op_1)
	);

	clb compute_block (
		.clk(clk),
		.rst(rst),
		.config_en(config_en_clb),
		.config_data(config_data[1:0]),
		.in0(op_0),
		.in1(op_1),
		.out(pe_output)
	);

	switch_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) sb (
		.clk(clk),
		.rst(rst),
		.config_en(config_en_sb),
		.config_data(config_data),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.pe_output(pe_output),
		.out_wire_0(out_wire_0),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2)
	);

	// decoded strobes never overlap.
	a_one_enable: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0({config_en_sb, config_en_cb0, config_en_cb1, config_en_clb})
	) else $error("pe_tile_top: more than one block write enable");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tile testbench with verilator.

cd "$(dirname "$0")" || exit 1

TOP=tb_pe_tile_top
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-Wno-fatal \
	-f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG_FILE"; then
	echo "simulation reported failure, see $LOG_FILE"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== switch_box.sv ====
`timescale 1ns/1ps

module switch_box #(
	parameter int NUM_TRACKS = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  config_en,
	input  cgra_pkg::cfg_data_t   config_data,
	input  logic [NUM_TRACKS-1:0] in_wire_0,
	input  logic [NUM_TRACKS-1:0] in_wire_1,
	input  logic [NUM_TRACKS-1:0] in_wire_2,
	input  logic [NUM_TRACKS-1:0] in_wire_3,
	input  logic                  pe_output,
	output logic [NUM_TRACKS-1:0] out_wire_0,
	output logic [NUM_TRACKS-1:0] out_wire_1,
	output logic [NUM_TRACKS-1:0] out_wire_2
);

	// two bits per output track, three output sides.
	localparam int USED_BITS = 2 * cgra_pkg::NUM_OUT_SIDES * NUM_TRACKS;
	localparam cgra_pkg::cfg_data_t USED_MASK =
		cgra_pkg::cfg_data_t'((64'd1 << USED_BITS) - 64'd1);

	cgra_pkg::cfg_data_t cfg_q;

	logic [NUM_TRACKS-1:0] side_in [cgra_pkg::NUM_IN_SIDES];
	logic [NUM_TRACKS-1:0] side_out [cgra_pkg::NUM_OUT_SIDES];

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_q <= '0; // every track from the lowest other side.
		end else if (config_en) begin
			cfg_q <= config_data;
		end
	end

	assign side_in[0] = in_wire_0;
	assign side_in[1] = in_wire_1;
	assign side_in[2] = in_wire_2;
	assign side_in[3] = in_wire_3;

	// choice c takes the c-th other side, counting upward and skipping s.
	for (genvar s = 0; s < cgra_pkg::NUM_OUT_SIDES; s++) begin : g_side
		localparam int SRC0 = (s == 0) ? 1 : 0;
		localparam int SRC1 = (s <= 1) ? 2 : 1;
		localparam int SRC2 = 3;

		for (genvar t = 0; t < NUM_TRACKS; t++) begin : g_track
			cgra_pkg::sb_choice_t choice;

			assign choice = cfg_q[2 * (s * NUM_TRACKS + t) +: 2];

			always_comb begin
				case (choice)
					2'd0: side_out[s][t] = side_in[SRC0][t];
					2'd1: side_out[s][t] = side_in[SRC1][t];
					2'd2: side_out[s][t] = side_in[SRC2][t];
					cgra_pkg::SB_FROM_PE: side_out[s][t] = pe_output;
					default: side_out[s][t] = 1'b0;
				endcase
			end
		end
	end

	assign out_wire_0 = side_out[0];
	assign out_wire_1 = side_out[1];
	assign out_wire_2 = side_out[2];

	// unused fields stay clear after a write.
	a_upper_clear: assert property (
		@(posedge clk) disable iff (rst)
		config_en |=> ((cfg_q & ~USED_MASK) == '0)
	) else $error("switch_box: config bits above field %0d set", USED_BITS);

endmodule

// ==== tb_pe_tile_top.sv ====
`timescale 1ns/1ps

module tb_pe_tile_top;

	localparam int NUM_TRACKS = 4;
	localparam int CLK_HALF = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int SAMPLE_DELAY = 3;
	localparam int SETTLE_LIMIT = 10;
	localparam int RUN_LIMIT_NS = 200000;
	localparam int RANDOM_ROWS = 60;
	localparam cgra_pkg::tile_id_t TILE_ID = 16'h00a5;
	localparam cgra_pkg::cfg_addr_t IDLE_ADDR = 32'h0000_0000; // tile field never matches.

	typedef logic [3:0][NUM_TRACKS-1:0] in_set_t;
	typedef logic [2:0][NUM_TRACKS-1:0] out_set_t;

	// one stimulus row, delayed means outputs are checked in the following cycle.
	typedef struct packed {
		cgra_pkg::cfg_addr_t addr;
		cgra_pkg::cfg_data_t data;
		in_set_t ins;
		logic delayed;
	} row_t;

	logic clk;
	logic rst;
	cgra_pkg::cfg_addr_t config_addr;
	cgra_pkg::cfg_data_t config_data;
	cgra_pkg::tile_id_t tile_id;
	logic [NUM_TRACKS-1:0] in_wire_0;
	logic [NUM_TRACKS-1:0] in_wire_1;
	logic [NUM_TRACKS-1:0] in_wire_2;
	logic [NUM_TRACKS-1:0] in_wire_3;
	logic [NUM_TRACKS-1:0] out_wire_0;
	logic [NUM_TRACKS-1:0] out_wire_1;
	logic [NUM_TRACKS-1:0] out_wire_2;

	// reference state of the tile.
	cgra_pkg::cfg_data_t model_sb;
	cgra_pkg::cb_sel_t model_cb0;
	cgra_pkg::cb_sel_t model_cb1;
	cgra_pkg::clb_op_t model_op;
	logic model_pe;

	row_t rows[$];
	int seed;
	int errors;
	int checks;
	int settle_count;

	pe_tile_top #(
		.NUM_TRACKS(NUM_TRACKS)
	) u_pe_tile_top (
		.clk(clk),
		.rst(rst),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id(tile_id),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.out_wire_0(out_wire_0),
		.out_wire_1(out_wire_1),
		.out_wire_2(out_wire_2)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	initial begin
		#(RUN_LIMIT_NS);
		$display("timeout: simulation did not reach the end of the table");
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] w;
		w = $random(seed);
		return w;
	endfunction

	function automatic in_set_t random_ins();
		logic [31:0] w;
		w = next_random();
		return w[4*NUM_TRACKS-1:0];
	endfunction

	function automatic cgra_pkg::cfg_addr_t block_addr(input cgra_pkg::block_id_t blk,
			input cgra_pkg::tile_id_t tile);
		return {blk, tile};
	endfunction

	function automatic cgra_pkg::cfg_data_t set_field(input cgra_pkg::cfg_data_t word,
			input int s, input int t, input logic [1:0] choice);
		word[2*(s*NUM_TRACKS+t) +: 2] = choice;
		return word;
	endfunction

	// choice 0..2 counts the other sides upward, 3 is the logic block.
	function automatic logic route_track(input int s, input int t, input logic [1:0] choice,
			input in_set_t ins, input logic pe);
		int cnt;
		logic val;
		cnt = 0;
		val = pe;
		if (choice != 2'd3) begin
			for (int side = 0; side < 4; side++) begin
				if (side != s) begin
					if (cnt == int'(choice))
						val = ins[side][t];
					cnt++;
				end
			end
		end
		return val;
	endfunction

	function automatic out_set_t expect_outs(input in_set_t ins);
		out_set_t outs;
		logic [1:0] choice;
		for (int s = 0; s < 3; s++) begin
			for (int t = 0; t < NUM_TRACKS; t++) begin
				choice = model_sb[2*(s*NUM_TRACKS+t) +: 2];
				outs[s][t] = route_track(s, t, choice, ins, model_pe);
			end
		end
		return outs;
	endfunction

	function automatic logic pick_operand(input cgra_pkg::cb_sel_t sel,
			input logic [NUM_TRACKS-1:0] side_in, input logic [NUM_TRACKS-1:0] side_out);
		int idx;
		idx = int'(sel);
		if (idx < 4)
			return side_in[idx];
		return side_out[idx-4]; // upper choices read what the tile drives out.
	endfunction

	function automatic logic apply_op(input cgra_pkg::clb_op_t op, input logic a,
			input logic b);
		case (op)
			cgra_pkg::OP_AND: return a & b;
			cgra_pkg::OP_OR: return a | b;
			cgra_pkg::OP_XOR: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	task automatic add_row(input cgra_pkg::cfg_addr_t addr, input cgra_pkg::cfg_data_t data,
			input in_set_t ins, input logic delayed);
		row_t r;
		r.addr = addr;
		r.data = data;
		r.ins = ins;
		r.delayed = delayed;
		rows.push_back(r);
	endtask

	// one clock cycle, entered and left 1 ns after the rising edge.
	task automatic run_cycle(input cgra_pkg::cfg_addr_t addr, input cgra_pkg::cfg_data_t data,
			input in_set_t ins, input logic check, input int row);
		out_set_t exp_outs;
		out_set_t got_outs;
		logic op_a;
		logic op_b;
		logic next_pe;
		cgra_pkg::cfg_data_t next_sb;
		cgra_pkg::cb_sel_t next_cb0;
		cgra_pkg::cb_sel_t next_cb1;
		cgra_pkg::clb_op_t next_op;
		config_addr = addr;
		config_data = data;
		in_wire_0 = ins[0];
		in_wire_1 = ins[1];
		in_wire_2 = ins[2];
		in_wire_3 = ins[3];
		#(SAMPLE_DELAY);
		exp_outs = expect_outs(ins);
		got_outs = {out_wire_2, out_wire_1, out_wire_0};
		if (check) begin
			for (int s = 0; s < 3; s++) begin
				checks++;
				assert (got_outs[s] === exp_outs[s]) else begin
					errors++;
					$display("CHECK FAILED at %0d ns: row %0d out_wire_%0d is %b, expected %b",
						$time, row, s, got_outs[s], exp_outs[s]);
				end
			end
		end
		op_a = pick_operand(model_cb0, ins[0], exp_outs[0]);
		op_b = pick_operand(model_cb1, ins[1], exp_outs[1]);
		next_pe = apply_op(model_op, op_a, op_b);
		next_sb = model_sb;
		next_cb0 = model_cb0;
		next_cb1 = model_cb1;
		next_op = model_op;
		if (addr[15:0] == TILE_ID) begin
			case (addr[31:16])
				cgra_pkg::BLOCK_SB: next_sb = data;
				cgra_pkg::BLOCK_CB0: next_cb0 = data[2:0];
				cgra_pkg::BLOCK_CB1: next_cb1 = data[2:0];
				cgra_pkg::BLOCK_CLB: next_op = data[1:0];
				default: ;
			endcase
		end
		@(posedge clk);
		model_pe = next_pe;
		model_sb = next_sb;
		model_cb0 = next_cb0;
		model_cb1 = next_cb1;
		model_op = next_op;
		#(DRIVE_DELAY);
	endtask

	task automatic build_table();
		cgra_pkg::cfg_data_t word;
		logic [31:0] r;
		// reset routing, choice 0 everywhere.
		add_row(IDLE_ADDR, '0, 16'h0000, 1'b0);
		add_row(IDLE_ADDR, '0, 16'hffff, 1'b0);
		add_row(IDLE_ADDR, '0, 16'h5a3c, 1'b0);
		add_row(IDLE_ADDR, '0, 16'hc381, 1'b0);
		// uniform switch box choices.
		for (int c = 0; c < 4; c++) begin
			word = '0;
			for (int i = 0; i < 3 * NUM_TRACKS; i++)
				word = set_field(word, i / NUM_TRACKS, i % NUM_TRACKS, 2'(c));
			add_row(block_addr(cgra_pkg::BLOCK_SB, TILE_ID), word, random_ins(), 1'b0);
			for (int k = 0; k < 3; k++)
				add_row(IDLE_ADDR, '0, random_ins(), 1'b0);
		end
		word = '0;
		for (int i = 0; i < 3 * NUM_TRACKS; i++)
			word = set_field(word, i / NUM_TRACKS, i % NUM_TRACKS, 2'((i * 3 + 1) % 4));
		add_row(block_addr(cgra_pkg::BLOCK_SB, TILE_ID), word, random_ins(), 1'b0);
		for (int k = 0; k < 3; k++)
			add_row(IDLE_ADDR, '0, random_ins(), 1'b0);
		// writes that must be ignored.
		add_row(block_addr(cgra_pkg::BLOCK_SB, TILE_ID ^ 16'h0001), next_random(),
			random_ins(), 1'b1);
		add_row(block_addr(cgra_pkg::BLOCK_CB0, TILE_ID ^ 16'h0100), 32'h7, random_ins(), 1'b1);
		add_row(block_addr(cgra_pkg::BLOCK_CB1, 16'h0000), 32'h6, random_ins(), 1'b1);
		add_row(block_addr(cgra_pkg::BLOCK_CLB, 16'hffff), 32'h3, random_ins(), 1'b1);
		add_row(block_addr(16'd0, TILE_ID), next_random(), random_ins(), 1'b1);
		add_row(block_addr(16'd3, TILE_ID), next_random(), random_ins(), 1'b1);
		add_row(block_addr(16'd8, TILE_ID), next_random(), random_ins(), 1'b1);
		add_row(block_addr(16'hffff, TILE_ID), next_random(), random_ins(), 1'b1);
		// side 2 shows the logic block, sides 0 and 1 mix their sources.
		word = '0;
		for (int t = 0; t < NUM_TRACKS; t++) begin
			word = set_field(word, 0, t, 2'(t % 4));
			word = set_field(word, 1, t, 2'((t + 1) % 4));
			word = set_field(word, 2, t, 2'd3);
		end
		add_row(block_addr(cgra_pkg::BLOCK_SB, TILE_ID), word, random_ins(), 1'b0);
		for (int op = 0; op < 4; op++) begin
			add_row(block_addr(cgra_pkg::BLOCK_CLB, TILE_ID), 32'(op), random_ins(), 1'b0);
			for (int sel = 0; sel < 8; sel++) begin
				add_row(block_addr(cgra_pkg::BLOCK_CB0, TILE_ID), 32'(sel), random_ins(), 1'b0);
				add_row(block_addr(cgra_pkg::BLOCK_CB1, TILE_ID), 32'(7 - sel), random_ins(),
					1'b0);
				for (int k = 0; k < 3; k++)
					add_row(IDLE_ADDR, '0, random_ins(), 1'b1);
			end
		end
		// fixed random configuration, then random traffic.
		word = next_random() & ((32'd1 << (6 * NUM_TRACKS)) - 32'd1); // used fields only.
		add_row(block_addr(cgra_pkg::BLOCK_SB, TILE_ID), word, random_ins(), 1'b0);
		add_row(block_addr(cgra_pkg::BLOCK_CB0, TILE_ID), next_random(), random_ins(), 1'b0);
		add_row(block_addr(cgra_pkg::BLOCK_CB1, TILE_ID), next_random(), random_ins(), 1'b0);
		add_row(block_addr(cgra_pkg::BLOCK_CLB, TILE_ID), next_random(), random_ins(), 1'b0);
		for (int k = 0; k < RANDOM_ROWS; k++) begin
			r = next_random();
			add_row(IDLE_ADDR, '0, random_ins(), r[5]);
		end
	endtask

	task automatic run_table();
		for (int i = 0; i < rows.size(); i++) begin
			run_cycle(rows[i].addr, rows[i].data, rows[i].ins, !rows[i].delayed, i);
			if (rows[i].delayed)
				run_cycle(IDLE_ADDR, '0, rows[i].ins, 1'b1, i); // same inputs, no write.
		end
	endtask

	initial begin
		seed = 15914;
		errors = 0;
		checks = 0;
		settle_count = 0;
		rst = 1'b1;
		config_addr = IDLE_ADDR;
		config_data = '0;
		tile_id = TILE_ID;
		in_wire_0 = '0;
		in_wire_1 = '0;
		in_wire_2 = '0;
		in_wire_3 = '0;
		model_sb = '0;
		model_cb0 = '0;
		model_cb1 = '0;
		model_op = cgra_pkg::OP_AND;
		model_pe = 1'b0;
		repeat (3) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		while ($isunknown({out_wire_0, out_wire_1, out_wire_2})
				&& settle_count < SETTLE_LIMIT) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			settle_count++;
		end
		if (settle_count >= SETTLE_LIMIT) begin
			errors++;
			$display("timeout: tile outputs stayed unknown after reset was released");
		end else begin
			build_table();
			run_table();
		end
		$display("rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
